// File: Bender.yml
package:
  name: lcd_display

sources:
  - rtl/lcd_instr_pkg.sv
  - rtl/lcd_timing_pkg.sv
  - rtl/lcd_req_if.sv
  - rtl/lcd_controller.sv
  - rtl/lcd_message_writer.sv
  - rtl/lcd_display_top.sv
  - target: test
    files:
      - verification/lcd_bus_checker.sv
      - verification/lcd_display_tb.sv

// File: files.f
rtl/lcd_instr_pkg.sv
rtl/lcd_timing_pkg.sv
rtl/lcd_req_if.sv
rtl/lcd_controller.sv
rtl/lcd_message_writer.sv
rtl/lcd_display_top.sv
verification/lcd_bus_checker.sv
verification/lcd_display_tb.sv

// File: rtl/lcd_controller.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_controller #(
	parameter int CLK_PER_US = 50
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire lcd_instr_pkg::lcd_cfg_t cfg,
	lcd_req_if.ctrl                   req_bus,
	output logic                      e,
	output logic                      rs,
	output lcd_instr_pkg::lcd_data_t  data
);
	import lcd_instr_pkg::*;
	import lcd_timing_pkg::*;

	// init step start points in microseconds, pulse then gap
	localparam int CTRL_START_US  = PULSE_US + FUNC_GAP_US;
	localparam int CLEAR_START_US = CTRL_START_US + PULSE_US + CTRL_GAP_US;
	localparam int ENTRY_START_US = CLEAR_START_US + PULSE_US + CLEAR_GAP_US;
	localparam int INIT_END_US    = ENTRY_START_US + PULSE_US + ENTRY_GAP_US;

	localparam dly_cnt_t POWERUP_CYC  = dly_cnt_t'(POWERUP_US * CLK_PER_US);
	localparam dly_cnt_t PULSE_CYC    = dly_cnt_t'(PULSE_US * CLK_PER_US);
	localparam dly_cnt_t FUNC_START   = dly_cnt_t'(0);
	localparam dly_cnt_t CTRL_START   = dly_cnt_t'(CTRL_START_US * CLK_PER_US);
	localparam dly_cnt_t CLEAR_START  = dly_cnt_t'(CLEAR_START_US * CLK_PER_US);
	localparam dly_cnt_t ENTRY_START  = dly_cnt_t'(ENTRY_START_US * CLK_PER_US);
	localparam dly_cnt_t INIT_CYC     = dly_cnt_t'(INIT_END_US * CLK_PER_US);
	localparam dly_cnt_t WRITE_CYC    = dly_cnt_t'(WRITE_US * CLK_PER_US);
	localparam dly_cnt_t EN_START_CYC = dly_cnt_t'(ENABLE_START_US * CLK_PER_US);
	localparam dly_cnt_t EN_END_CYC   = dly_cnt_t'(ENABLE_END_US * CLK_PER_US);

	typedef enum logic [1:0] {
		ST_POWERUP,
		ST_INIT,
		ST_IDLE,
		ST_WRITE
	} state_t;

	state_t    state;
	dly_cnt_t  cnt;
	dly_cnt_t  cnt_inc;
	dly_cnt_t  init_pos;	// init position the registered outputs will show
	logic      init_e;
	lcd_data_t init_data;
	logic      busy;

	function automatic logic in_pulse(dly_cnt_t pos, dly_cnt_t start);
		return (pos >= start) && (pos < start + PULSE_CYC);
	endfunction

	assign cnt_inc      = cnt + 1'b1;
	assign init_pos     = (state == ST_INIT) ? cnt_inc : '0;
	assign req_bus.busy = busy;

	always_comb begin
		init_e = 1'b1;
		if (in_pulse(init_pos, FUNC_START))
			init_data = func_set_cmd(cfg);
		else if (in_pulse(init_pos, CTRL_START))
			init_data = disp_ctrl_cmd(cfg);
		else if (in_pulse(init_pos, CLEAR_START))
			init_data = CLEAR_CMD;
		else if (in_pulse(init_pos, ENTRY_START))
			init_data = entry_cmd(cfg);
		else begin
			init_e    = 1'b0;	// gap between steps
			init_data = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_POWERUP;
			cnt   <= '0;
			busy  <= 1'b1;
			e     <= 1'b0;
			rs    <= 1'b0;
			data  <= '0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == POWERUP_CYC - 1'b1) begin
						state <= ST_INIT;
						cnt   <= '0;
						e     <= init_e;	// function set pulse starts here
						data  <= init_data;
					end else begin
						cnt <= cnt_inc;
					end
				end
				ST_INIT: begin
					if (cnt == INIT_CYC - 1'b1) begin
						state <= ST_IDLE;
						cnt   <= '0;
						busy  <= 1'b0;
						e     <= 1'b0;
						data  <= '0;
					end else begin
						cnt  <= cnt_inc;
						e    <= init_e;
						data <= init_data;
					end
				end
				ST_IDLE: begin
					if (req_bus.req) begin
						state <= ST_WRITE;
						cnt   <= '0;
						busy  <= 1'b1;
						rs    <= req_bus.rs;	// held for the whole write
						data  <= req_bus.data;
					end
				end
				ST_WRITE: begin
					if (cnt == WRITE_CYC - 1'b1) begin
						state <= ST_IDLE;
						cnt   <= '0;
						busy  <= 1'b0;
						e     <= 1'b0;
						rs    <= 1'b0;
						data  <= '0;
					end else begin
						cnt <= cnt_inc;
						e   <= (cnt_inc >= EN_START_CYC) && (cnt_inc < EN_END_CYC);
					end
				end
				default: state <= ST_POWERUP;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/lcd_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_display_top #(
	parameter int CLK_PER_US = 50,
	parameter int FIFO_DEPTH = 8
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire lcd_instr_pkg::lcd_cfg_t display_cfg,
	input  wire                          char_valid,
	input  wire                          char_line,
	input  wire lcd_instr_pkg::lcd_data_t char_code,
	output wire                          char_full,
	output wire                          lcd_e,
	output wire                          lcd_rs,
	output wire lcd_instr_pkg::lcd_data_t lcd_data
);

	lcd_req_if req_bus ();	// writer to controller

	lcd_message_writer #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) writer_i (
		.clk        (clk),
		.rst        (rst),
		.char_valid (char_valid),
		.char_line  (char_line),
		.char_code  (char_code),
		.char_full  (char_full),
		.req_bus    (req_bus.host)
	);

	lcd_controller #(
		.CLK_PER_US (CLK_PER_US)
	) ctrl_i (
		.clk     (clk),
		.rst     (rst),
		.cfg     (display_cfg),
		.req_bus (req_bus.ctrl),
		.e       (lcd_e),
		.rs      (lcd_rs),
		.data    (lcd_data)
	);

endmodule

`default_nettype wire

// File: rtl/lcd_instr_pkg.sv
`default_nettype none

package lcd_instr_pkg;

	typedef logic [7:0] lcd_data_t;	// one byte on the lcd data bus
	typedef logic [6:0] lcd_cfg_t;	// {lines, font, disp_on, cursor, blink, inc_dec, shift}
	typedef logic [3:0] col_t;	// cursor column within a line

	localparam lcd_data_t FUNC_SET_BASE  = 8'h30;	// 8-bit bus
	localparam lcd_data_t DISP_CTRL_BASE = 8'h08;
	localparam lcd_data_t CLEAR_CMD      = 8'h01;
	localparam lcd_data_t ENTRY_BASE     = 8'h04;
	localparam lcd_data_t DDRAM_SET      = 8'h80;
	localparam lcd_data_t LINE1_OFFSET   = 8'h40;	// ddram start of second line

	function automatic lcd_data_t func_set_cmd(lcd_cfg_t cfg);
		return FUNC_SET_BASE | {4'b0000, cfg[6], cfg[5], 2'b00};	// N and F bits
	endfunction

	function automatic lcd_data_t disp_ctrl_cmd(lcd_cfg_t cfg);
		return DISP_CTRL_BASE | {5'b00000, cfg[4:2]};	// D, C, B
	endfunction

	function automatic lcd_data_t entry_cmd(lcd_cfg_t cfg);
		return ENTRY_BASE | {6'b000000, cfg[1:0]};	// I/D and S
	endfunction

	function automatic lcd_data_t ddram_cmd(logic line, col_t col);
		return DDRAM_SET | (line ? LINE1_OFFSET : 8'h00) | {4'h0, col};
	endfunction

endpackage

`default_nettype wire

// File: rtl/lcd_message_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_message_writer #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        char_valid,
	input  wire                        char_line,
	input  wire lcd_instr_pkg::lcd_data_t char_code,
	output logic                       char_full,
	lcd_req_if.host                    req_bus
);
	import lcd_instr_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [1:0] {
		ST_PICK,
		ST_ADDR_SENT,
		ST_CHAR_SENT
	} state_t;

	logic [8:0]       fifo_mem [FIFO_DEPTH];	// {line, code}
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic             push;
	logic             fifo_empty;
	logic             head_line;
	lcd_data_t        head_code;

	state_t state;
	logic   cur_line;
	col_t   col;
	logic   col_wrap;	// ran past column 15
	logic   pos_known;	// ddram address set at least once
	logic   need_addr;
	logic   issue_addr;
	logic   issue_char;

	function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign char_full               = (fill == CNT_W'(FIFO_DEPTH));
	assign fifo_empty              = (fill == '0);
	assign push                    = char_valid && !char_full;	// drop when full
	assign {head_line, head_code}  = fifo_mem[rd_ptr];

	assign need_addr  = !pos_known || (head_line != cur_line) || col_wrap;
	assign issue_addr = (state == ST_PICK) && !fifo_empty && !req_bus.busy && need_addr;
	assign issue_char = !req_bus.busy && !fifo_empty &&
		(((state == ST_PICK) && !need_addr) || (state == ST_ADDR_SENT));

	assign req_bus.req  = issue_addr || issue_char;
	assign req_bus.rs   = issue_char;
	assign req_bus.data = issue_addr ? ddram_cmd(head_line, col_t'(0)) : head_code;

	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_ptr] <= {char_line, char_code};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (issue_char)
				rd_ptr <= ptr_next(rd_ptr);	// pop with the char request
			case ({push, issue_char})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_PICK;
			cur_line  <= 1'b0;
			col       <= '0;
			col_wrap  <= 1'b0;
			pos_known <= 1'b0;
		end else begin
			if (issue_addr) begin
				cur_line  <= head_line;
				col       <= '0;
				col_wrap  <= 1'b0;
				pos_known <= 1'b1;
			end else if (issue_char) begin
				col <= col + 1'b1;
				if (col == 4'hf)
					col_wrap <= 1'b1;	// next char needs a fresh address
			end

			case (state)
				ST_PICK: begin
					if (issue_addr)
						state <= ST_ADDR_SENT;
					else if (issue_char)
						state <= ST_CHAR_SENT;
				end
				ST_ADDR_SENT: begin
					if (issue_char)
						state <= ST_CHAR_SENT;	// char follows once address is done
				end
				ST_CHAR_SENT: begin
					if (!req_bus.busy)
						state <= ST_PICK;
				end
				default: state <= ST_PICK;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/lcd_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lcd_req_if;
	import lcd_instr_pkg::*;

	logic      req;	// one-cycle strobe, only while busy is low
	logic      rs;	// 0 instruction, 1 character
	lcd_data_t data;
	logic      busy;	// level from controller

	modport host (
		output req,
		output rs,
		output data,
		input  busy
	);

	modport ctrl (
		input  req,
		input  rs,
		input  data,
		output busy
	);

endinterface

`default_nettype wire

// File: rtl/lcd_timing_pkg.sv
`default_nettype none

package lcd_timing_pkg;

	typedef logic [15:0] dly_cnt_t;	// shared delay counter

	// all durations in microseconds
	localparam int POWERUP_US      = 500;
	localparam int PULSE_US        = 10;	// enable pulse during init
	localparam int FUNC_GAP_US     = 50;
	localparam int CTRL_GAP_US     = 50;
	localparam int CLEAR_GAP_US    = 200;	// clear is the slow one
	localparam int ENTRY_GAP_US    = 100;

	localparam int WRITE_US        = 50;	// full single write slot
	localparam int ENABLE_START_US = 1;	// e rises, setup for rs/data
	localparam int ENABLE_END_US   = 14;	// e falls, write takes effect

endpackage

`default_nettype wire

// File: verification/lcd_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_checker #(
	parameter int CLK_PER_US = 2
) (
	input wire                           clk,
	input wire                           rst,
	input wire                           char_full,
	input wire                           lcd_e,
	input wire                           lcd_rs,
	input wire lcd_instr_pkg::lcd_data_t lcd_data
);
	import lcd_instr_pkg::*;
	import lcd_timing_pkg::*;

	localparam int POWERUP_CYC = POWERUP_US * CLK_PER_US;

	logic [8:0] exp_q [$];	// {rs, data} in write order
	int         exp_cnt = 0;
	int         seen_cnt = 0;
	int         mismatch_cnt = 0;
	int         other_cnt = 0;
	int         since_rst = 0;

	logic       model_known = 1'b0;	// address set in the model
	logic       model_line = 1'b0;
	int         model_col = 0;

	logic       e_prev = 1'b0;
	logic       cap_rs = 1'b0;
	lcd_data_t  cap_data = '0;
	logic       saw_full = 1'b0;
	logic       idle_bad = 1'b0;

	// HD44780 bit positions N=3 F=2 in function set
	// D=2 C=1 B=0 in display control and I/D=1 S=0 in entry mode
	task automatic expect_init(input lcd_cfg_t cfg);
		exp_q.push_back({1'b0, FUNC_SET_BASE | (lcd_data_t'(cfg[6]) << 3)
			| (lcd_data_t'(cfg[5]) << 2)});
		exp_q.push_back({1'b0, DISP_CTRL_BASE | (lcd_data_t'(cfg[4]) << 2)
			| (lcd_data_t'(cfg[3]) << 1) | lcd_data_t'(cfg[2])});
		exp_q.push_back({1'b0, CLEAR_CMD});
		exp_q.push_back({1'b0, ENTRY_BASE | (lcd_data_t'(cfg[1]) << 1)
			| lcd_data_t'(cfg[0])});
		exp_cnt = exp_cnt + 4;
	endtask

	task automatic expect_char(input logic line, input lcd_data_t code);
		if (!model_known || (line != model_line) || (model_col > 15)) begin
			exp_q.push_back({1'b0, DDRAM_SET | (line ? LINE1_OFFSET : 8'h00)});	// column 0
			exp_cnt++;
			model_known = 1'b1;
			model_line  = line;
			model_col   = 0;
		end
		exp_q.push_back({1'b1, code});
		exp_cnt++;
		model_col++;
	endtask

	task automatic compare_write(input logic rs, input lcd_data_t data);
		logic [8:0] exp_w;
		if (seen_cnt >= exp_cnt) begin
			$display("unexpected extra write at %0t ns: rs=%0b data=0x%02h", $time, rs, data);
			other_cnt++;
		end else begin
			exp_w = exp_q[seen_cnt];
			if ({rs, data} !== exp_w) begin
				$write("MISMATCH at %0t ns: write %0d expected rs=%0b data=0x%02h",
					$time, seen_cnt, exp_w[8], exp_w[7:0]);
				$display(", got rs=%0b data=0x%02h", rs, data);
				mismatch_cnt++;
			end
		end
		seen_cnt++;
	endtask

	task automatic finish_checks();
		if (seen_cnt < exp_cnt) begin
			$display("missing writes: only %0d of %0d writes reached the display",
				seen_cnt, exp_cnt);
			other_cnt++;
		end
		if (!saw_full) begin
			$display("char_full never went high during the push burst");
			other_cnt++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			since_rst <= 0;
			e_prev    <= 1'b0;
		end else begin
			since_rst <= since_rst + 1;
			if (char_full)
				saw_full <= 1'b1;
			if ((since_rst == 0) && char_full) begin
				$display("char_full was high right after reset");
				other_cnt++;
			end
			// pins must stay quiet through the power-up wait
			if ((since_rst < POWERUP_CYC) && !idle_bad &&
				(lcd_e || lcd_rs || (lcd_data != '0))) begin
				$display("LCD pins active at %0t ns, before the power-up wait ended", $time);
				other_cnt++;
				idle_bad <= 1'b1;
			end
			if (lcd_e) begin
				cap_rs   <= lcd_rs;
				cap_data <= lcd_data;
			end else if (e_prev) begin
				compare_write(cap_rs, cap_data);	// falling edge of e
			end
			e_prev <= lcd_e;
		end
	end

endmodule

`default_nettype wire

// File: verification/lcd_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_display_tb;
	import lcd_instr_pkg::*;

	localparam int       CLK_PER_US = 2;
	localparam int       FIFO_DEPTH = 8;
	localparam int       INIT_CYC   = 940 * CLK_PER_US;	// power-up plus init steps
	localparam lcd_cfg_t CFG        = 7'b1011010;	// 2 lines, 5x8, display and cursor on

	logic      clk;
	logic      rst;
	lcd_cfg_t  display_cfg;
	logic      char_valid;
	logic      char_line;
	lcd_data_t char_code;
	wire       char_full;
	wire       lcd_e;
	wire       lcd_rs;
	wire lcd_data_t lcd_data;

	logic        tbl_line [$];
	lcd_data_t   tbl_code [$];
	logic [31:0] lcg_state;
	int          cycles = 0;
	int          limit = 0;	// set once the table is built
	int          gap;
	int          idx;
	int          k;

	lcd_display_top #(
		.CLK_PER_US (CLK_PER_US),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut_i (
		.clk         (clk),
		.rst         (rst),
		.display_cfg (display_cfg),
		.char_valid  (char_valid),
		.char_line   (char_line),
		.char_code   (char_code),
		.char_full   (char_full),
		.lcd_e       (lcd_e),
		.lcd_rs      (lcd_rs),
		.lcd_data    (lcd_data)
	);

	lcd_bus_checker #(
		.CLK_PER_US (CLK_PER_US)
	) checker_i (
		.clk       (clk),
		.rst       (rst),
		.char_full (char_full),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_data  (lcd_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_segment(input logic line, input string text);
		for (int i = 0; i < text.len(); i++) begin
			tbl_line.push_back(line);
			tbl_code.push_back(lcd_data_t'(text[i]));
		end
	endtask

	task automatic finish_run(input logic timed_out);
		int errors;
		checker_i.finish_checks();
		errors = checker_i.mismatch_cnt + checker_i.other_cnt;
		$display("errors: %0d mismatches, %0d other, timeout %0b",
			checker_i.mismatch_cnt, checker_i.other_cnt, timed_out);
		if ((errors == 0) && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((limit > 0) && (cycles >= limit)) begin
			$display("timeout after %0d cycles, the display did not receive every write", cycles);
			finish_run(1'b1);
		end
	end

	initial begin
		rst         = 1'b1;
		display_cfg = CFG;
		char_valid  = 1'b0;
		char_line   = 1'b0;
		char_code   = '0;
		lcg_state   = 32'd91;
		gap         = 0;
		idx         = 0;

		add_segment(1'b0, "Hi ");
		add_segment(1'b1, "status");
		add_segment(1'b0, "ok");
		add_segment(1'b1, "0123456789ABCDEFGH");	// 17th char wraps
		add_segment(1'b0, "end");
		limit = INIT_CYC + 220 * tbl_code.size() + 500;

		checker_i.expect_init(CFG);
		for (k = 0; k < tbl_code.size(); k++)
			checker_i.expect_char(tbl_line[k], tbl_code[k]);

		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// one push at most every other cycle, so full is seen before the next push
		while (idx < tbl_code.size()) begin
			@(posedge clk);
			if (char_valid) begin
				char_valid <= 1'b0;
			end else if (gap != 0) begin
				gap--;
			end else if (!char_full) begin
				char_line  <= tbl_line[idx];
				char_code  <= tbl_code[idx];
				char_valid <= 1'b1;
				idx++;
				lcg_state = lcg_next(lcg_state);
				gap       = int'(lcg_state[17:16]) % 3;
			end
		end
		@(posedge clk);
		char_valid <= 1'b0;

		while (checker_i.seen_cnt < checker_i.exp_cnt)
			@(negedge clk);
		finish_run(1'b0);
	end

endmodule

`default_nettype wire
